//--- include/rv_core_params.svh
// core-wide sizing defines and the reset fetch address
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// data path and address width
`define RV_XLEN 32

// integer register file
`define RV_NUM_REGS 32
`define RV_REG_AW 5

// first instruction fetched after reset
`define RV_RESET_PC 32'h8000_0000

`endif

//--- source/rv_core_pkg.sv
// shared types: opcodes, instruction formats, ALU operations, decoded instruction
`include "rv_core_params.svh"

package rv_core_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_NONE  // unsupported opcode
    } inst_type_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef struct packed {
        opcode_t               opcode;     // raw bits kept for unknown opcodes too
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_XLEN-1:0]   imm;        // sign-extended
        inst_type_t            inst_type;
        alu_op_t               alu_op;
    } decoded_t;

endpackage

//--- source/rv_wb_if.sv
// write-back bundle from execute to the register file and retire ports
`include "rv_core_params.svh"

interface rv_wb_if;
    logic                  valid;  // one instruction finishing this cycle
    logic                  we;     // already low for x0 and non-writing ops
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
    logic [`RV_XLEN-1:0]   pc;

    // driven by the execute unit
    modport source (
        output valid, we, rd, data, pc
    );

    // register file and retire side
    modport sink (
        input valid, we, rd, data, pc
    );
endinterface

//--- source/rv_fetch.sv
// fetch unit: program counter, FETCH/EXEC controller and instruction latch
`include "rv_core_params.svh"

module rv_fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                imem_valid,
    input  logic [`RV_XLEN-1:0] imem_rdata,
    input  logic [`RV_XLEN-1:0] next_pc,
    output logic                imem_req,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] inst,
    output logic                exec_valid
);
    typedef enum logic {
        FETCH,
        EXEC
    } state_t;

    state_t state;
    logic   run;       // holds off the first request for a cycle after reset
    logic   fetch_done;

    assign imem_req   = run && (state == FETCH);
    assign exec_valid = (state == EXEC);
    assign fetch_done = imem_req && imem_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
            pc    <= `RV_RESET_PC;
        end else begin
            case (state)
                FETCH: if (fetch_done) state <= EXEC;
                EXEC: begin
                    state <= FETCH;  // execute is always a single cycle
                    pc    <= next_pc;
                end
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) inst <= imem_rdata;
    end

    // address has to hold until the memory answers
    assert property (@(posedge clk) disable iff (reset)
        imem_req && !imem_valid |=> $stable(pc));

    assert property (@(posedge clk) disable iff (reset)
        exec_valid |=> !exec_valid);
endmodule

//--- source/rv_decoder.sv
// instruction decoder: fields, format, immediates and ALU operation
`include "rv_core_params.svh"

module rv_decoder (
    input  logic [`RV_XLEN-1:0]   inst,
    output rv_core_pkg::decoded_t dec
);
    logic alt;  // funct7 bit 5, selects SUB and SRA

    assign alt = inst[30];

    always_comb begin
        dec.opcode = rv_core_pkg::opcode_t'(inst[6:0]);
        dec.funct3 = inst[14:12];
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];

        case (inst[6:0])
            rv_core_pkg::OPC_OP:     dec.inst_type = rv_core_pkg::TYPE_R;
            rv_core_pkg::OPC_OP_IMM,
            rv_core_pkg::OPC_JALR:   dec.inst_type = rv_core_pkg::TYPE_I;
            rv_core_pkg::OPC_BRANCH: dec.inst_type = rv_core_pkg::TYPE_B;
            rv_core_pkg::OPC_LUI,
            rv_core_pkg::OPC_AUIPC:  dec.inst_type = rv_core_pkg::TYPE_U;
            rv_core_pkg::OPC_JAL:    dec.inst_type = rv_core_pkg::TYPE_J;
            default:                 dec.inst_type = rv_core_pkg::TYPE_NONE;
        endcase

        case (dec.inst_type)
            rv_core_pkg::TYPE_I: dec.imm = {{20{inst[31]}}, inst[31:20]};
            rv_core_pkg::TYPE_B:
                dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_core_pkg::TYPE_U: dec.imm = {inst[31:12], 12'h000};
            rv_core_pkg::TYPE_J:
                dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:             dec.imm = '0;
        endcase

        // address and upper-immediate math all use ADD
        dec.alu_op = rv_core_pkg::ALU_ADD;
        if (dec.inst_type == rv_core_pkg::TYPE_R ||
            inst[6:0] == rv_core_pkg::OPC_OP_IMM) begin
            case (inst[14:12])
                3'b000: begin
                    if (dec.inst_type == rv_core_pkg::TYPE_R && alt) begin
                        dec.alu_op = rv_core_pkg::ALU_SUB;  // no SUBI in the ISA
                    end
                end
                3'b001: dec.alu_op = rv_core_pkg::ALU_SLL;
                3'b010: dec.alu_op = rv_core_pkg::ALU_SLT;
                3'b011: dec.alu_op = rv_core_pkg::ALU_SLTU;
                3'b100: dec.alu_op = rv_core_pkg::ALU_XOR;
                3'b101: dec.alu_op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
                3'b110: dec.alu_op = rv_core_pkg::ALU_OR;
                3'b111: dec.alu_op = rv_core_pkg::ALU_AND;
                default: dec.alu_op = rv_core_pkg::ALU_ADD;
            endcase
        end
    end
endmodule

//--- source/rv_regfile.sv
// integer register file, two combinational read ports and one write port
`include "rv_core_params.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`RV_REG_AW-1:0] rs1,
    input  logic [`RV_REG_AW-1:0] rs2,
    rv_wb_if.sink                 wb,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2
);
    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];
    logic                wr_en;

    assign wr_en = wb.valid && wb.we;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 is hardwired to zero
    always_comb begin
        rdata1 = (rs1 == '0) ? '0 : regs[rs1];
        rdata2 = (rs2 == '0) ? '0 : regs[rs2];
    end

    // execute is expected to drop writes aimed at x0
    assert property (@(posedge clk) disable iff (reset)
        wr_en |-> wb.rd != '0);
endmodule

//--- source/rv_execute.sv
// ALU, branch compare, jump targets and write-back select
`include "rv_core_params.svh"

module rv_execute (
    input  rv_core_pkg::decoded_t dec,
    input  logic [`RV_XLEN-1:0]   pc,
    input  logic                  exec_valid,
    input  logic [`RV_XLEN-1:0]   rdata1,
    input  logic [`RV_XLEN-1:0]   rdata2,
    output logic [`RV_XLEN-1:0]   next_pc,
    rv_wb_if.source               wb
);
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic                cond;    // branch condition from funct3
    logic                taken;
    logic                is_link; // JAL or JALR
    logic                writes;

    assign pc_plus4 = pc + `RV_XLEN'(4);
    assign is_link  = (dec.opcode == rv_core_pkg::OPC_JAL) ||
                      (dec.opcode == rv_core_pkg::OPC_JALR);

    always_comb begin
        alu_a = rdata1;
        alu_b = rdata2;
        case (dec.inst_type)
            rv_core_pkg::TYPE_I: alu_b = dec.imm;
            rv_core_pkg::TYPE_U: begin
                alu_a = (dec.opcode == rv_core_pkg::OPC_LUI) ? '0 : pc;
                alu_b = dec.imm;
            end
            rv_core_pkg::TYPE_B, rv_core_pkg::TYPE_J: begin
                alu_a = pc;  // target = pc + offset
                alu_b = dec.imm;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            rv_core_pkg::ALU_SUB:  alu_y = alu_a - alu_b;
            rv_core_pkg::ALU_SLL:  alu_y = alu_a << alu_b[4:0];
            rv_core_pkg::ALU_SLT:  alu_y = `RV_XLEN'($signed(alu_a) < $signed(alu_b));
            rv_core_pkg::ALU_SLTU: alu_y = `RV_XLEN'(alu_a < alu_b);
            rv_core_pkg::ALU_XOR:  alu_y = alu_a ^ alu_b;
            rv_core_pkg::ALU_SRL:  alu_y = alu_a >> alu_b[4:0];
            rv_core_pkg::ALU_SRA:  alu_y = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            rv_core_pkg::ALU_OR:   alu_y = alu_a | alu_b;
            rv_core_pkg::ALU_AND:  alu_y = alu_a & alu_b;
            default:               alu_y = alu_a + alu_b;
        endcase
    end

    // branches compare the register operands, not the ALU inputs
    always_comb begin
        case (dec.funct3)
            3'b000:  cond = (rdata1 == rdata2);
            3'b001:  cond = (rdata1 != rdata2);
            3'b100:  cond = $signed(rdata1) < $signed(rdata2);
            3'b101:  cond = $signed(rdata1) >= $signed(rdata2);
            3'b110:  cond = rdata1 < rdata2;
            3'b111:  cond = rdata1 >= rdata2;
            default: cond = 1'b0;  // reserved encodings fall through
        endcase
    end

    assign taken = (dec.inst_type == rv_core_pkg::TYPE_B) && cond;

    always_comb begin
        if (dec.opcode == rv_core_pkg::OPC_JALR) begin
            next_pc = {alu_y[`RV_XLEN-1:1], 1'b0};
        end else if (dec.opcode == rv_core_pkg::OPC_JAL || taken) begin
            next_pc = alu_y;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // branches and unknown opcodes leave the register file alone
    assign writes = (dec.inst_type != rv_core_pkg::TYPE_B) &&
                    (dec.inst_type != rv_core_pkg::TYPE_NONE);

    assign wb.valid = exec_valid;
    assign wb.we    = writes && (dec.rd != '0);
    assign wb.rd    = dec.rd;
    assign wb.data  = is_link ? pc_plus4 : alu_y;
    assign wb.pc    = pc;
endmodule

//--- source/rv_core.sv
// rv_core top level: fetch, decode, register file and execute units
`include "rv_core_params.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  imem_valid,
    input  logic [`RV_XLEN-1:0]   imem_rdata,
    output logic                  imem_req,
    output logic [`RV_XLEN-1:0]   imem_addr,
    output logic                  retire_valid,
    output logic [`RV_XLEN-1:0]   retire_pc,
    output logic [`RV_REG_AW-1:0] retire_rd,
    output logic                  retire_we,
    output logic [`RV_XLEN-1:0]   retire_wdata
);
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   inst;
    logic [`RV_XLEN-1:0]   next_pc;
    logic                  exec_valid;
    logic [`RV_XLEN-1:0]   rdata1;
    logic [`RV_XLEN-1:0]   rdata2;
    rv_core_pkg::decoded_t dec;

    rv_wb_if wb_if ();

    rv_fetch fetch_i (
        .clk        (clk),
        .reset      (reset),
        .imem_valid (imem_valid),
        .imem_rdata (imem_rdata),
        .next_pc    (next_pc),
        .imem_req   (imem_req),
        .pc         (pc),
        .inst       (inst),
        .exec_valid (exec_valid)
    );

    rv_decoder decoder_i (
        .inst (inst),
        .dec  (dec)
    );

    rv_regfile regfile_i (
        .clk    (clk),
        .reset  (reset),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .wb     (wb_if.sink),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rv_execute execute_i (
        .dec        (dec),
        .pc         (pc),
        .exec_valid (exec_valid),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .next_pc    (next_pc),
        .wb         (wb_if.source)
    );

    assign imem_addr = pc;  // held by fetch until imem_valid

    // retire port mirrors the write-back bundle
    assign retire_valid = wb_if.valid;
    assign retire_pc    = wb_if.pc;
    assign retire_rd    = wb_if.rd;
    assign retire_we    = wb_if.we;
    assign retire_wdata = wb_if.data;
endmodule

//--- tests/rv_core_checker.sv
// retire and fetch monitor for rv_core
// compares each retired instruction with the expectation table
`include "rv_core_params.svh"

module rv_core_checker #(
    parameter int ROWS           = 1,
    parameter int RETIRE_TIMEOUT = 32
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           imem_req,
    input  logic [`RV_XLEN-1:0]            imem_addr,
    input  logic                           imem_valid,
    input  logic                           retire_valid,
    input  logic [`RV_XLEN-1:0]            retire_pc,
    input  logic [`RV_REG_AW-1:0]          retire_rd,
    input  logic                           retire_we,
    input  logic [`RV_XLEN-1:0]            retire_wdata,
    input  logic [ROWS-1:0][`RV_XLEN-1:0]  exp_pc,
    input  logic [ROWS-1:0][`RV_REG_AW-1:0] exp_rd,
    input  logic [ROWS-1:0]                exp_we,
    input  logic [ROWS-1:0][`RV_XLEN-1:0]  exp_wdata,
    output logic                           done,
    output logic                           timed_out,
    output int                             rows_passed,
    output int                             errors
);
    int                  row_errors;
    int                  fetch_errors = 0;
    int                  row_bad;
    logic                hold_prev;   // request open and unanswered last cycle
    logic                resp_prev;   // memory answered last cycle
    logic                seen_req;
    logic [`RV_XLEN-1:0] addr_prev;

    assign errors = row_errors + fetch_errors;

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, got %h", name, expected, actual);
            row_bad++;
        end
    endtask

    // fetch link and reset behavior
    always @(posedge clk) begin
        if (reset) begin
            if (imem_req === 1'b1 || retire_valid === 1'b1) begin
                $display("request or retire seen while reset was asserted");
                fetch_errors++;
            end
            hold_prev <= 1'b0;
            resp_prev <= 1'b0;
            seen_req  <= 1'b0;
        end else begin
            if (imem_req && !seen_req && imem_addr !== `RV_RESET_PC) begin
                $display("Fail imem_addr: expected %h, got %h", `RV_RESET_PC, imem_addr);
                fetch_errors++;
            end
            if (hold_prev && !imem_req) begin
                $display("fetch request dropped before the memory answered");
                fetch_errors++;
            end
            if (hold_prev && imem_addr !== addr_prev) begin
                $display("Fail imem_addr: expected %h, got %h", addr_prev, imem_addr);
                fetch_errors++;
            end
            if (retire_valid !== resp_prev) begin  // exactly one cycle after imem_valid
                $display("Fail retire_valid: expected %h, got %h", resp_prev, retire_valid);
                fetch_errors++;
            end
            if (imem_req) seen_req <= 1'b1;
            hold_prev <= imem_req && !imem_valid;
            resp_prev <= imem_req && imem_valid;
            addr_prev <= imem_addr;
        end
    end

    initial begin
        int waited;
        done        = 1'b0;
        timed_out   = 1'b0;
        rows_passed = 0;
        row_errors  = 0;
        for (int r = 0; r < ROWS && !timed_out; r++) begin
            waited = 0;
            @(posedge clk);
            while (retire_valid !== 1'b1 && waited < RETIRE_TIMEOUT) begin
                @(posedge clk);
                waited++;
            end
            if (retire_valid !== 1'b1) begin
                $display("row %0d never retired within %0d cycles", r, RETIRE_TIMEOUT);
                timed_out = 1'b1;
            end else begin
                row_bad = 0;
                check_field("retire_pc", exp_pc[r], retire_pc);
                check_field("retire_we", exp_we[r], retire_we);
                if (exp_we[r]) begin  // rd and data only matter on a write
                    check_field("retire_rd", exp_rd[r], retire_rd);
                    check_field("retire_wdata", exp_wdata[r], retire_wdata);
                end
                row_errors += row_bad;
                if (row_bad == 0) begin
                    rows_passed++;
                    $display("row %0d at %h ok", r, retire_pc);
                end else begin
                    $display("row %0d at %h failed", r, retire_pc);
                end
            end
        end
        done = 1'b1;
    end
endmodule

//--- tests/rv_core_tb.sv
// clock, reset and an instruction memory model with random latency
// program with its expectation table, DUT and checker instances
`include "rv_core_params.svh"

module rv_core_tb;
    localparam int N_ROWS   = 36;
    localparam int MEM_SIZE = 64;

    logic                  clk        = 1'b0;
    logic                  reset      = 1'b1;
    logic                  imem_valid = 1'b0;
    logic [`RV_XLEN-1:0]   imem_rdata = '0;
    logic                  imem_req;
    logic [`RV_XLEN-1:0]   imem_addr;
    logic                  retire_valid;
    logic [`RV_XLEN-1:0]   retire_pc;
    logic [`RV_REG_AW-1:0] retire_rd;
    logic                  retire_we;
    logic [`RV_XLEN-1:0]   retire_wdata;

    logic [N_ROWS-1:0][31:0] row_inst;
    logic [N_ROWS-1:0][31:0] row_pc;
    logic [N_ROWS-1:0][31:0] row_wdata;
    logic [N_ROWS-1:0][4:0]  row_rd;
    logic [N_ROWS-1:0]       row_we;
    int                      n_rows = 0;

    logic [31:0] mem [MEM_SIZE];
    logic [31:0] word_index;
    logic        busy;
    int          idle_left;
    integer      gap;
    integer      seed = 32'hcc40;

    logic done;
    logic timed_out;
    int   rows_passed;
    int   errors;

    always #4 clk = ~clk;

    rv_core rv_core_i (
        .clk          (clk),
        .reset        (reset),
        .imem_valid   (imem_valid),
        .imem_rdata   (imem_rdata),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_we    (retire_we),
        .retire_wdata (retire_wdata)
    );

    rv_core_checker #(.ROWS(N_ROWS)) checker_i (
        .clk (clk), .reset (reset), .imem_req (imem_req), .imem_addr (imem_addr),
        .imem_valid (imem_valid), .retire_valid (retire_valid), .retire_pc (retire_pc),
        .retire_rd (retire_rd), .retire_we (retire_we), .retire_wdata (retire_wdata),
        .exp_pc (row_pc), .exp_rd (row_rd), .exp_we (row_we), .exp_wdata (row_wdata),
        .done (done), .timed_out (timed_out), .rows_passed (rows_passed), .errors (errors)
    );

    // RV32I instruction encoders
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        r_word = {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        i_word = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        b_word = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        u_word = {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
        j_word = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_row(input logic [31:0] off, input logic [31:0] inst,
                           input logic [4:0] rd, input logic we, input logic [31:0] wdata);
        row_pc[n_rows]    = `RV_RESET_PC + off;
        row_inst[n_rows]  = inst;
        row_rd[n_rows]    = rd;
        row_we[n_rows]    = we;
        row_wdata[n_rows] = wdata;
        n_rows++;
    endtask

    // rows in execution order with x1 = -5 and x2 = 3 for the compares below
    task automatic load_program();
        add_row('h00, i_word(12'hffb, 0, 3'd0, 1, rv_core_pkg::OPC_OP_IMM), 1, 1'b1, 32'hffff_fffb);
        add_row('h04, i_word(12'h003, 0, 3'd0, 2, rv_core_pkg::OPC_OP_IMM), 2, 1'b1, 32'h3);
        add_row('h08, r_word(7'h00, 2, 1, 3'd0, 3), 3, 1'b1, 32'hffff_fffe);
        add_row('h0c, r_word(7'h20, 1, 2, 3'd0, 4), 4, 1'b1, 32'h8);          // sub
        add_row('h10, r_word(7'h00, 2, 1, 3'd2, 5), 5, 1'b1, 32'h1);          // slt
        add_row('h14, r_word(7'h00, 2, 1, 3'd3, 6), 6, 1'b1, 32'h0);          // sltu
        add_row('h18, r_word(7'h00, 2, 1, 3'd4, 7), 7, 1'b1, 32'hffff_fff8);
        add_row('h1c, r_word(7'h00, 2, 1, 3'd6, 8), 8, 1'b1, 32'hffff_fffb);
        add_row('h20, r_word(7'h00, 2, 1, 3'd7, 9), 9, 1'b1, 32'h3);
        add_row('h24, r_word(7'h00, 2, 2, 3'd1, 10), 10, 1'b1, 32'h18);       // sll
        add_row('h28, r_word(7'h00, 2, 1, 3'd5, 11), 11, 1'b1, 32'h1fff_ffff);
        add_row('h2c, r_word(7'h20, 2, 1, 3'd5, 12), 12, 1'b1, 32'hffff_ffff); // sra
        add_row('h30, i_word(12'h007, 1, 3'd0, 0, rv_core_pkg::OPC_OP_IMM), 0, 1'b0, 32'h0);
        add_row('h34, r_word(7'h00, 2, 0, 3'd0, 13), 13, 1'b1, 32'h3);        // x0 reads zero
        add_row('h38, u_word(20'h12345, 14, rv_core_pkg::OPC_LUI), 14, 1'b1, 32'h1234_5000);
        add_row('h3c, u_word(20'h00001, 15, rv_core_pkg::OPC_AUIPC), 15, 1'b1, 32'h8000_103c);
        add_row('h40, b_word(13'h008, 13, 2, 3'd0), 0, 1'b0, 32'h0);  // beq taken
        add_row('h48, b_word(13'h008, 13, 2, 3'd1), 0, 1'b0, 32'h0);  // bne not taken
        add_row('h4c, b_word(13'h008, 2, 1, 3'd1), 0, 1'b0, 32'h0);
        add_row('h54, b_word(13'h008, 2, 1, 3'd4), 0, 1'b0, 32'h0);   // blt taken
        add_row('h5c, b_word(13'h008, 1, 2, 3'd4), 0, 1'b0, 32'h0);
        add_row('h60, b_word(13'h008, 1, 2, 3'd5), 0, 1'b0, 32'h0);   // bge taken
        add_row('h68, b_word(13'h008, 2, 1, 3'd5), 0, 1'b0, 32'h0);
        add_row('h6c, b_word(13'h008, 1, 2, 3'd6), 0, 1'b0, 32'h0);   // bltu taken
        add_row('h74, b_word(13'h008, 2, 1, 3'd6), 0, 1'b0, 32'h0);
        add_row('h78, b_word(13'h008, 2, 1, 3'd7), 0, 1'b0, 32'h0);   // bgeu taken
        add_row('h80, b_word(13'h008, 1, 2, 3'd7), 0, 1'b0, 32'h0);
        add_row('h84, b_word(13'h008, 2, 1, 3'd0), 0, 1'b0, 32'h0);   // beq not taken
        add_row('h88, j_word(21'h00000c, 16), 16, 1'b1, 32'h8000_008c);
        add_row('h94, u_word(20'h00000, 17, rv_core_pkg::OPC_AUIPC), 17, 1'b1, 32'h8000_0094);
        // odd jalr target drops bit 0
        add_row('h98, i_word(12'h021, 17, 3'd0, 18, rv_core_pkg::OPC_JALR), 18, 1'b1,
                32'h8000_009c);
        add_row('hb4, i_word(12'h000, 16, 3'd0, 19, rv_core_pkg::OPC_OP_IMM), 19, 1'b1,
                32'h8000_008c);
        add_row('hb8, 32'h0050_050b, 0, 1'b0, 32'h0);  // unsupported custom-0 opcode
        add_row('hbc, i_word(12'h001, 0, 3'd0, 20, rv_core_pkg::OPC_OP_IMM), 20, 1'b1, 32'h1);
        add_row('hc0, i_word(12'h401, 1, 3'd5, 21, rv_core_pkg::OPC_OP_IMM), 21, 1'b1,
                32'hffff_fffd);
        add_row('hc4, i_word(12'hfff, 1, 3'd4, 22, rv_core_pkg::OPC_OP_IMM), 22, 1'b1, 32'h4);
    endtask

    assign word_index = (imem_addr - `RV_RESET_PC) >> 2;

    // memory model answers after 0 to 3 idle cycles
    always @(posedge clk) begin
        if (reset) begin
            imem_valid <= 1'b0;
            busy       <= 1'b0;
        end else if (imem_valid) begin
            imem_valid <= 1'b0;  // single-cycle pulse
        end else if (busy) begin
            if (idle_left == 0) begin
                imem_valid <= 1'b1;
                imem_rdata <= mem[word_index[5:0]];
                busy       <= 1'b0;
            end else begin
                idle_left <= idle_left - 1;
            end
        end else if (imem_req) begin
            gap = $random(seed) & 3;
            if (gap == 0) begin
                imem_valid <= 1'b1;
                imem_rdata <= mem[word_index[5:0]];
            end else begin
                busy      <= 1'b1;
                idle_left <= gap - 1;
            end
        end
    end

    initial begin
        int waited;
        for (int i = 0; i < MEM_SIZE; i++) begin
            mem[i] = {i[24:0], 7'h7f};  // unsupported opcode tagged by index
        end
        load_program();
        for (int r = 0; r < N_ROWS; r++) begin
            mem[(row_pc[r] - `RV_RESET_PC) >> 2] = row_inst[r];
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        waited = 0;
        while (!done && waited < 2000) begin
            @(posedge clk);
            waited++;
        end
        @(negedge clk);  // checker counters settle after the last rising edge
        if (!done) $display("checker did not finish within 2000 cycles");
        $display("%0d of %0d rows passed, %0d errors", rows_passed, N_ROWS, errors);
        if (!done || timed_out || errors != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end
endmodule

//--- rv_core.f
+incdir+include
source/rv_core_pkg.sv
source/rv_wb_if.sv
source/rv_fetch.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_core.sv
tests/rv_core_checker.sv
tests/rv_core_tb.sv
